// ==== testbench/tsfSyncStim.txt ====
# cmd bssType ap beaconInt value aux expTimer expModulo (hex)
# load: value=timer, aux=ticks; rx: value=timeStamp, aux=frmDur; softrst: value!=0 starts divider
load 0 0 0064 0000000100000000 5 0000000100000005 0000000
rx 1 0 0064 0000000200000000 10 0000000100000005 0000000
sync 1 0 0064 0 0 0000000200000010 0002010
rx 0 0 0064 0000000100000000 0 0000000200000010 0002010
sync 0 0 0064 0 0 0000000200000010 0002010
rx 0 0 0064 0000000300000400 20 0000000200000010 0002010
sync 1 1 0064 0 0 0000000200000010 0002010
sync 0 0 0064 0 0 0000000300000420 0003420
active 0 0 00c8 0 0 0000000300000420 001c420
load 0 0 00c8 00000000000ffc00 3 00000000000ffc03 001c420
active 0 0 0007 0 0 00000000000ffc03 0000403
softrst 0 0 0007 1 0 0000000000000000 0000000
rx 1 0 0064 0000000000012345 3 0000000000000000 0000000
sync 1 0 0064 0 0 0000000000012348 0012348
load 0 0 0064 ffffffff00000000 2 ffffffff00000002 0012348
active 0 0 0001 0 0 ffffffff00000002 0000002
rx 1 0 0001 0000000000000000 0 ffffffff00000002 0000002
sync 1 0 0400 0 0 0000000000000000 0000000

// ==== list.f ====
logic/tsfSyncPkg.sv
logic/tsfSyncCtrl.sv
logic/tsfTimekeeper.sv
logic/tsfModuloDivider.sv
logic/tsfSync.sv
testbench/tsfSyncProps.sv
testbench/tsfSyncTb.sv

// ==== Makefile ====
# Verilator build and run for the TSF synchronization block

VERILATOR ?= verilator
TOP       ?= tsfSyncTb
BUILD     ?= obj_dir
LOG       ?= sim.log
FLIST     ?= list.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FLIST))
STIM := testbench/tsfSyncStim.txt
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

run: $(BIN) $(STIM)
	./$(BIN) | tee $(LOG)

check: run
	@if grep -q "^Done: no errors$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== testbench/tsfSyncTb.sv ====
// TSF synchronization testbench driving scenarios from the stimulus file and checking results
module tsfSyncTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam string stimFile = "testbench/tsfSyncStim.txt";
  localparam int clkPeriod = 4;
  localparam int resetCycles = 16;
  // Cycle budget per stimulus line
  localparam int cyclesPerLine = 100;
  localparam int pulseLimit = 70;
  // Edge counts from the sampled strobe, seen at falling edges
  localparam int syncDelay = 59;
  localparam int activeDelay = 57;

  // One parsed stimulus line
  typedef struct packed {
    logic        bssType;
    logic        ap;
    logic [15:0] beaconInt;
    logic [63:0] value;
    logic [63:0] aux;
    logic [63:0] expTimer;
    logic [25:0] expModulo;
  } stimRow_t;

  logic                      macCoreClk;
  logic                      macCoreClkHardRst_n;
  logic                      macCoreClkSoftRst_n;
  logic                      tsfUpdatePulse;
  logic                      tsfOffsetUpdate_p;
  logic                      macPhyIfRxEndForTiming_p;
  logic                      moveToActive_p;
  logic                      tick1us_p;
  tsfSyncPkg::rxBeacon_t     rxBeacon;
  tsfSyncPkg::bssCfg_t       bssCfg;
  tsfSyncPkg::swLoad_t       swLoad;
  logic [63:0]               tsfTimer;
  logic                      tsfUpdatedBySWInValid;
  logic [25:0]               modulo;
  logic                      updateBeaconIntCnt_p;

  string       cmdQ[$];
  stimRow_t    rowQ[$];
  int          numLines = 0;
  bit          stimReady = 0;
  int          errCount = 0;
  int          checkCount = 0;

  // Reference state kept from the synchronization rules
  logic [63:0] modelTimer;
  logic [63:0] modelOffset;
  logic        modelLesser;
  logic [25:0] modelModulo;

  tsfSync u_dut (
    .macCoreClk               (macCoreClk),
    .macCoreClkHardRst_n      (macCoreClkHardRst_n),
    .macCoreClkSoftRst_n      (macCoreClkSoftRst_n),
    .tsfUpdatePulse           (tsfUpdatePulse),
    .tsfOffsetUpdate_p        (tsfOffsetUpdate_p),
    .macPhyIfRxEndForTiming_p (macPhyIfRxEndForTiming_p),
    .moveToActive_p           (moveToActive_p),
    .tick1us_p                (tick1us_p),
    .rxBeacon                 (rxBeacon),
    .bssCfg                   (bssCfg),
    .swLoad                   (swLoad),
    .tsfTimer                 (tsfTimer),
    .tsfUpdatedBySWInValid    (tsfUpdatedBySWInValid),
    .modulo                   (modulo),
    .updateBeaconIntCnt_p     (updateBeaconIntCnt_p)
  );

  always #(clkPeriod / 2) macCoreClk = ~macCoreClk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // TSF modulo interval, taken in TU with the fraction kept
  function automatic logic [25:0] expectModulo(input logic [63:0] t, input logic [15:0] bi);
    logic [63:0] tu;
    logic [63:0] rem;
    tu = t >> 10;
    rem = tu % {48'd0, bi};
    return {rem[15:0], t[9:0]};
  endfunction

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    checkCount++;
    assert (got === exp)
    else
    begin
      $display("ERR %s exp=%h got=%h", name, exp, got);
      errCount++;
    end
  endtask

  // Strobes drop after one cycle, then look for the reload pulse
  task automatic waitPulse(input int limit, output int cycles, output bit seen);
    cycles = 0;
    seen = 0;
    while (!seen && cycles < limit)
    begin
      @(negedge macCoreClk);
      tsfUpdatePulse = 1'b0;
      moveToActive_p = 1'b0;
      cycles++;
      seen = updateBeaconIntCnt_p;
    end
  endtask

  task automatic readStim();
    int    fd;
    int    n;
    string line;
    string cmd;
    logic [63:0] f[7];
    fd = $fopen(stimFile, "r");
    if (fd == 0)
    begin
      $display("Could not open the stimulus file %s", stimFile);
      errCount++;
      return;
    end
    while ($fgets(line, fd) > 0)
    begin
      if (line.len() < 2 || line.substr(0, 0) == "#")
        continue;
      n = $sscanf(line, "%s %h %h %h %h %h %h %h", cmd, f[0], f[1], f[2], f[3], f[4],
                  f[5], f[6]);
      if (n != 8)
      begin
        $display("Malformed stimulus line: %s", line);
        errCount++;
        continue;
      end
      cmdQ.push_back(cmd);
      rowQ.push_back('{f[0][0], f[1][0], f[2][15:0], f[3], f[4], f[5], f[6][25:0]});
    end
    $fclose(fd);
  endtask

  //////////////////////////////
  // One scenario
  //////////////////////////////

  task automatic runRow(input string cmd, input stimRow_t row);
    int  cycles;
    bit  seen;
    logic [63:0] rxEnd;
    bssCfg.bssType = row.bssType;
    bssCfg.ap = row.ap;
    bssCfg.beaconInt = row.beaconInt;
    case (cmd)
      "load":
      begin
        swLoad = {1'b1, row.value};
        @(negedge macCoreClk);
        swLoad.tsfUpdatedBySW = 1'b0;
        checkValue("tsfUpdatedBySWInValid", {63'd0, tsfUpdatedBySWInValid}, 64'd1);
        @(negedge macCoreClk);
        checkValue("tsfUpdatedBySWInValid", {63'd0, tsfUpdatedBySWInValid}, 64'd0);
        // Back to back ticks
        for (int i = 0; i < int'(row.aux); i++)
        begin
          tick1us_p = 1'b1;
          @(negedge macCoreClk);
        end
        tick1us_p = 1'b0;
        @(negedge macCoreClk);
        modelTimer = row.value + row.aux;
      end
      "rx":
      begin
        rxBeacon.timeStamp = row.value;
        rxBeacon.frmDurWithoutMH = row.aux[15:0];
        macPhyIfRxEndForTiming_p = 1'b1;
        @(negedge macCoreClk);
        macPhyIfRxEndForTiming_p = 1'b0;
        tsfOffsetUpdate_p = 1'b1;
        @(negedge macCoreClk);
        tsfOffsetUpdate_p = 1'b0;
        repeat (3) @(negedge macCoreClk);
        rxEnd = row.value + {48'd0, row.aux[15:0]};
        modelOffset = rxEnd - modelTimer;
        modelLesser = (rxEnd > modelTimer);
      end
      "sync":
      begin
        tsfUpdatePulse = 1'b1;
        waitPulse(pulseLimit, cycles, seen);
        if ((row.bssType && !row.ap) || (!row.bssType && modelLesser))
        begin
          assert (seen)
          else
          begin
            $display("No reload pulse within %0d cycles after sync", pulseLimit);
            errCount++;
          end
          checkValue("pulseDelay", 64'(cycles), 64'(syncDelay));
          modelTimer = modelTimer + modelOffset;
          modelModulo = expectModulo(modelTimer, row.beaconInt);
        end
        else
        begin
          assert (!seen)
          else
          begin
            $display("Reload pulse after a sync that must be ignored");
            errCount++;
          end
        end
      end
      "active":
      begin
        moveToActive_p = 1'b1;
        waitPulse(pulseLimit, cycles, seen);
        assert (seen)
        else
        begin
          $display("No reload pulse within %0d cycles after move to active", pulseLimit);
          errCount++;
        end
        checkValue("pulseDelay", 64'(cycles), 64'(activeDelay));
        modelModulo = expectModulo(modelTimer, row.beaconInt);
      end
      "softrst":
      begin
        // Optionally start the divider so a pulse is pending
        if (row.value != 64'd0)
        begin
          moveToActive_p = 1'b1;
          @(negedge macCoreClk);
          moveToActive_p = 1'b0;
          repeat (4) @(negedge macCoreClk);
        end
        macCoreClkSoftRst_n = 1'b0;
        @(negedge macCoreClk);
        macCoreClkSoftRst_n = 1'b1;
        waitPulse(pulseLimit, cycles, seen);
        assert (!seen)
        else
        begin
          $display("Reload pulse still came after the soft reset");
          errCount++;
        end
        modelTimer = '0;
        modelOffset = '0;
        modelLesser = 1'b0;
        modelModulo = '0;
      end
      default:
      begin
        $display("Unknown stimulus command %s", cmd);
        errCount++;
      end
    endcase
    checkValue("tsfTimer", tsfTimer, row.expTimer);
    checkValue("tsfTimer", tsfTimer, modelTimer);
    checkValue("modulo", {38'd0, modulo}, {38'd0, row.expModulo});
    checkValue("modulo", {38'd0, modulo}, {38'd0, modelModulo});
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial
  begin
    macCoreClk = 1'b0;
    macCoreClkHardRst_n = 1'b0;
    macCoreClkSoftRst_n = 1'b1;
    tsfUpdatePulse = 1'b0;
    tsfOffsetUpdate_p = 1'b0;
    macPhyIfRxEndForTiming_p = 1'b0;
    moveToActive_p = 1'b0;
    tick1us_p = 1'b0;
    rxBeacon = '0;
    bssCfg = '0;
    swLoad = '0;
    modelTimer = '0;
    modelOffset = '0;
    modelLesser = 1'b0;
    modelModulo = '0;
    readStim();
    numLines = cmdQ.size();
    stimReady = 1;
    repeat (resetCycles) @(negedge macCoreClk);
    macCoreClkHardRst_n = 1'b1;
    @(negedge macCoreClk);
    foreach (cmdQ[i])
      runRow(cmdQ[i], rowQ[i]);
    $display("Checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // Watchdog sized by the number of scenarios
  initial
  begin
    wait (stimReady);
    #((resetCycles + 10 + numLines * cyclesPerLine) * clkPeriod);
    $display("Timeout: the scenarios did not finish in time");
    $display("Done: errors found");
    $finish;
  end

endmodule

// ==== testbench/tsfSyncProps.sv ====
// TSF synchronization protocol properties bound into the top level
module tsfSyncProps (
  input logic        macCoreClk,
  input logic        macCoreClkHardRst_n,
  input logic        macCoreClkSoftRst_n,
  input logic        swLoadReq,
  input logic [15:0] beaconInt,
  input logic [63:0] tsfTimer,
  input logic        tsfUpdatedBySWInValid,
  input logic [25:0] modulo,
  input logic        updateBeaconIntCnt_p
);
  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////
  // Pulse shape
  //////////////////////////////

  // Reload request is a single cycle
  reloadOneCycle: assert property (@(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    updateBeaconIntCnt_p |=> !updateBeaconIntCnt_p)
    else $error("reload pulse longer than one cycle");

  // Valid flag is the load request one cycle late
  validFollowsLoad: assert property (@(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    $past(macCoreClkSoftRst_n) |-> (tsfUpdatedBySWInValid == $past(swLoadReq)))
    else $error("software load valid flag out of step");

  //////////////////////////////
  // Result range
  //////////////////////////////

  // Remainder in TU below the interval
  moduloInRange: assert property (@(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    updateBeaconIntCnt_p |-> (modulo[25:10] < beaconInt))
    else $error("modulo remainder not below beacon interval");

  // Outputs quiet after either reset
  hardRstQuiet: assert property (@(posedge macCoreClk)
    !macCoreClkHardRst_n |=> (!updateBeaconIntCnt_p && !tsfUpdatedBySWInValid))
    else $error("outputs active after hard reset");

  softRstQuiet: assert property (@(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    !macCoreClkSoftRst_n |=> (!updateBeaconIntCnt_p && !tsfUpdatedBySWInValid &&
                              (tsfTimer == 64'd0)))
    else $error("outputs active after soft reset");

endmodule

bind tsfSync tsfSyncProps u_props (
  .macCoreClk            (macCoreClk),
  .macCoreClkHardRst_n   (macCoreClkHardRst_n),
  .macCoreClkSoftRst_n   (macCoreClkSoftRst_n),
  .swLoadReq             (swLoad.tsfUpdatedBySW),
  .beaconInt             (bssCfg.beaconInt),
  .tsfTimer              (tsfTimer),
  .tsfUpdatedBySWInValid (tsfUpdatedBySWInValid),
  .modulo                (modulo),
  .updateBeaconIntCnt_p  (updateBeaconIntCnt_p)
);

// ==== logic/tsfSync.sv ====
// TSF synchronization top level joining controller, timekeeper and modulo divider
module tsfSync (
  // Clock and resets
  input  logic                              macCoreClk,
  input  logic                              macCoreClkHardRst_n,
  input  logic                              macCoreClkSoftRst_n,
  // RX controller and MAC-PHY strobes
  input  logic                              tsfUpdatePulse,
  input  logic                              tsfOffsetUpdate_p,
  input  logic                              macPhyIfRxEndForTiming_p,
  // MAC controller and timer unit
  input  logic                              moveToActive_p,
  input  logic                              tick1us_p,
  input  tsfSyncPkg::rxBeacon_t             rxBeacon,
  // Register interface
  input  tsfSyncPkg::bssCfg_t               bssCfg,
  input  tsfSyncPkg::swLoad_t               swLoad,
  output logic [tsfSyncPkg::tsfWidth-1:0]    tsfTimer,
  output logic                              tsfUpdatedBySWInValid,
  // Beacon interval counter reload
  output logic [tsfSyncPkg::moduloWidth-1:0] modulo,
  output logic                              updateBeaconIntCnt_p
);

  tsfSyncPkg::tsfSyncState_e syncState;
  logic                      tsfLocalLesser;
  logic                      divDone;

  //////////////////////////////
  // Update decision
  //////////////////////////////

  tsfSyncCtrl u_tsfSyncCtrl (
    .macCoreClk           (macCoreClk),
    .macCoreClkHardRst_n  (macCoreClkHardRst_n),
    .macCoreClkSoftRst_n  (macCoreClkSoftRst_n),
    .tsfUpdatePulse       (tsfUpdatePulse),
    .moveToActive_p       (moveToActive_p),
    .tsfLocalLesser       (tsfLocalLesser),
    .divDone              (divDone),
    .bssCfg               (bssCfg),
    .syncState            (syncState),
    .updateBeaconIntCnt_p (updateBeaconIntCnt_p)
  );

  // Timer and offset
  tsfTimekeeper u_tsfTimekeeper (
    .macCoreClk               (macCoreClk),
    .macCoreClkHardRst_n      (macCoreClkHardRst_n),
    .macCoreClkSoftRst_n      (macCoreClkSoftRst_n),
    .syncState                (syncState),
    .macPhyIfRxEndForTiming_p (macPhyIfRxEndForTiming_p),
    .tsfOffsetUpdate_p        (tsfOffsetUpdate_p),
    .tick1us_p                (tick1us_p),
    .rxBeacon                 (rxBeacon),
    .swLoad                   (swLoad),
    .tsfTimer                 (tsfTimer),
    .tsfLocalLesser           (tsfLocalLesser),
    .tsfUpdatedBySWInValid    (tsfUpdatedBySWInValid)
  );

  // Modulo of the timer by the beacon interval
  tsfModuloDivider u_tsfModuloDivider (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .macCoreClkSoftRst_n (macCoreClkSoftRst_n),
    .syncState           (syncState),
    .tsfTimer            (tsfTimer),
    .beaconInt           (bssCfg.beaconInt),
    .modulo              (modulo),
    .divDone             (divDone)
  );

endmodule

// ==== logic/tsfModuloDivider.sv ====
// Serial restoring divider computing the TSF modulo the beacon interval in microseconds
module tsfModuloDivider (
  input  logic                                  macCoreClk,
  input  logic                                  macCoreClkHardRst_n,
  input  logic                                  macCoreClkSoftRst_n,
  input  tsfSyncPkg::tsfSyncState_e             syncState,
  input  logic [tsfSyncPkg::tsfWidth-1:0]       tsfTimer,
  input  logic [tsfSyncPkg::beaconIntWidth-1:0] beaconInt,
  output logic [tsfSyncPkg::moduloWidth-1:0]    modulo,
  output logic                                  divDone
);

  // TSF in TU, shifted out MSB first
  logic [tsfSyncPkg::moduloSteps-1:0]    dividend;
  // TU fraction passes straight to the result
  logic [tsfSyncPkg::tuShift-1:0]        tuFraction;
  // One spare bit since the remainder stays below twice the interval
  logic [tsfSyncPkg::beaconIntWidth:0]   remainder;
  logic [tsfSyncPkg::beaconIntWidth:0]   remDiff;
  logic                                  remGeInt;
  logic [tsfSyncPkg::stepCntWidth-1:0]   stepCnt;

  assign remDiff  = remainder - {1'b0, beaconInt};
  assign remGeInt = (remainder >= {1'b0, beaconInt});
  assign divDone  = (syncState == tsfSyncPkg::waitModValid) &&
                    (stepCnt == tsfSyncPkg::lastStep);

  //////////////////////////////
  // Dividend shift register
  //////////////////////////////

  always_ff @(posedge macCoreClk)
  begin
    if (syncState == tsfSyncPkg::trigDivider)
      dividend <= tsfTimer[tsfSyncPkg::tsfWidth-1:tsfSyncPkg::tuShift];
    else if (syncState == tsfSyncPkg::waitModValid)
      dividend <= {dividend[tsfSyncPkg::moduloSteps-2:0], 1'b0};
  end

  //////////////////////////////
  // Remainder and step count
  //////////////////////////////

  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      remainder  <= '0;
      stepCnt    <= '0;
      tuFraction <= '0;
    end
    else if (!macCoreClkSoftRst_n)
    begin
      remainder  <= '0;
      stepCnt    <= '0;
      tuFraction <= '0;
    end
    else if (syncState == tsfSyncPkg::trigDivider)
    begin
      remainder  <= '0;
      stepCnt    <= '0;
      tuFraction <= tsfTimer[tsfSyncPkg::tuShift-1:0];
    end
    else if (syncState == tsfSyncPkg::waitModValid)
    begin
      stepCnt <= stepCnt + 1'b1;
      // Subtract when possible, then bring in the next dividend bit
      if (remGeInt)
        remainder <= {remDiff[tsfSyncPkg::beaconIntWidth-1:0],
                      dividend[tsfSyncPkg::moduloSteps-1]};
      else
        remainder <= {remainder[tsfSyncPkg::beaconIntWidth-1:0],
                      dividend[tsfSyncPkg::moduloSteps-1]};
    end
    // Last subtraction brings the remainder below the interval
    else if ((syncState == tsfSyncPkg::waitAnotherClock) && remGeInt)
      remainder <= remDiff;
  end

  // Back to microseconds
  assign modulo = {remainder[tsfSyncPkg::beaconIntWidth-1:0], tuFraction};

endmodule

// ==== logic/tsfTimekeeper.sv ====
// TSF timekeeper holding the microsecond timer, received offset and sender-ahead flag
module tsfTimekeeper (
  input  logic                           macCoreClk,
  input  logic                           macCoreClkHardRst_n,
  input  logic                           macCoreClkSoftRst_n,
  input  tsfSyncPkg::tsfSyncState_e      syncState,
  // Frame timing strobes
  input  logic                           macPhyIfRxEndForTiming_p,
  input  logic                           tsfOffsetUpdate_p,
  input  logic                           tick1us_p,
  input  tsfSyncPkg::rxBeacon_t          rxBeacon,
  input  tsfSyncPkg::swLoad_t            swLoad,
  output logic [tsfSyncPkg::tsfWidth-1:0] tsfTimer,
  output logic                           tsfLocalLesser,
  output logic                           tsfUpdatedBySWInValid
);

  logic [tsfSyncPkg::tsfWidth-1:0] tsfOffset;
  logic [tsfSyncPkg::tsfWidth-1:0] rxTsfAtEnd;
  logic                            offsetUpdateDly_p;

  // Sender TSF projected to the end of the frame
  assign rxTsfAtEnd = rxBeacon.timeStamp +
                      {{(tsfSyncPkg::tsfWidth - tsfSyncPkg::frmDurWidth){1'b0}},
                       rxBeacon.frmDurWithoutMH};

  //////////////////////////////
  // Received offset
  //////////////////////////////

  // Captured at the RX end used as timing reference
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      tsfOffset <= '0;
    else if (!macCoreClkSoftRst_n)
      tsfOffset <= '0;
    else if (macPhyIfRxEndForTiming_p)
      tsfOffset <= rxTsfAtEnd - tsfTimer;
  end

  // Comparison runs one cycle after the offset update strobe
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      offsetUpdateDly_p <= 1'b0;
      tsfLocalLesser    <= 1'b0;
    end
    else if (!macCoreClkSoftRst_n)
    begin
      offsetUpdateDly_p <= 1'b0;
      tsfLocalLesser    <= 1'b0;
    end
    else
    begin
      offsetUpdateDly_p <= tsfOffsetUpdate_p;
      // Sender ahead when adding the offset moves the timer forward
      if (offsetUpdateDly_p)
        tsfLocalLesser <= ((tsfTimer + tsfOffset) > tsfTimer);
    end
  end

  //////////////////////////////
  // TSF timer
  //////////////////////////////

  // Offset update, then software load, then the 1 us tick
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      tsfTimer <= '0;
    else if (!macCoreClkSoftRst_n)
      tsfTimer <= '0;
    else if (syncState == tsfSyncPkg::updateTsf)
      tsfTimer <= tsfTimer + tsfOffset;
    else if (swLoad.tsfUpdatedBySW)
      tsfTimer <= {swLoad.tsfTimerHigh, swLoad.tsfTimerLow};
    else if (tick1us_p)
      tsfTimer <= tsfTimer + 1'b1;
  end

  // Lets software clear its load request one cycle later
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      tsfUpdatedBySWInValid <= 1'b0;
    else if (!macCoreClkSoftRst_n)
      tsfUpdatedBySWInValid <= 1'b0;
    else
      tsfUpdatedBySWInValid <= swLoad.tsfUpdatedBySW;
  end

endmodule

// ==== logic/tsfSyncCtrl.sv ====
// TSF synchronization controller deciding on timer updates and sequencing the modulo divider
module tsfSyncCtrl (
  input  logic                      macCoreClk,
  input  logic                      macCoreClkHardRst_n,
  input  logic                      macCoreClkSoftRst_n,
  // Strobes from RX controller and MAC controller
  input  logic                      tsfUpdatePulse,
  input  logic                      moveToActive_p,
  // Status from timekeeper and divider
  input  logic                      tsfLocalLesser,
  input  logic                      divDone,
  input  tsfSyncPkg::bssCfg_t       bssCfg,
  output tsfSyncPkg::tsfSyncState_e syncState,
  output logic                      updateBeaconIntCnt_p
);

  tsfSyncPkg::tsfSyncState_e syncStateNext;
  logic                      adoptOffset;

  // Infrastructure station always follows its AP
  // IBSS member follows only a sender that is ahead
  assign adoptOffset = (bssCfg.bssType && !bssCfg.ap) ||
                       (!bssCfg.bssType && tsfLocalLesser);

  //////////////////////////////
  // State register
  //////////////////////////////

  // Soft reset wins over everything, then the move-to-active restart
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      syncState <= tsfSyncPkg::idle;
    else if (!macCoreClkSoftRst_n)
      syncState <= tsfSyncPkg::idle;
    else if (moveToActive_p)
      syncState <= tsfSyncPkg::trigDivider;
    else
      syncState <= syncStateNext;
  end

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb
  begin
    syncStateNext = syncState;
    case (syncState)
      // Wait for the end of a Beacon or Probe Response
      tsfSyncPkg::idle:
        if (tsfUpdatePulse)
          syncStateNext = tsfSyncPkg::checkUpdate;
      // Apply BSS or IBSS rule, drop the frame otherwise
      tsfSyncPkg::checkUpdate:
        if (adoptOffset)
          syncStateNext = tsfSyncPkg::updateTsf;
        else
          syncStateNext = tsfSyncPkg::idle;
      // Timer takes the offset here
      tsfSyncPkg::updateTsf:
        syncStateNext = tsfSyncPkg::trigDivider;
      // Divider snapshots the updated timer
      tsfSyncPkg::trigDivider:
        syncStateNext = tsfSyncPkg::waitModValid;
      // One dividend bit per cycle until the last step
      tsfSyncPkg::waitModValid:
        if (divDone)
          syncStateNext = tsfSyncPkg::waitAnotherClock;
      // Final remainder correction
      tsfSyncPkg::waitAnotherClock:
        syncStateNext = tsfSyncPkg::updateBcnIntvCnt;
      tsfSyncPkg::updateBcnIntvCnt:
        syncStateNext = tsfSyncPkg::idle;
      default:
        syncStateNext = tsfSyncPkg::idle;
    endcase
  end

  // Reload request to the timer unit, one cycle wide
  assign updateBeaconIntCnt_p = (syncState == tsfSyncPkg::updateBcnIntvCnt);

endmodule

// ==== logic/tsfSyncPkg.sv ====
// TSF synchronization package with widths, controller states and grouped port types
package tsfSyncPkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // TSF timer in microseconds
  localparam int tsfWidth = 64;
  // Beacon interval counted in TU
  localparam int beaconIntWidth = 16;
  // Frame duration after the MAC header
  localparam int frmDurWidth = 16;
  // One TU is 1024 us
  localparam int tuShift = 10;
  // Modulo result in us, remainder in TU joined with the TU fraction
  localparam int moduloWidth = beaconIntWidth + tuShift;

  //////////////////////////////
  // Divider sequencing
  //////////////////////////////

  // TSF bits above the TU fraction go through the divider
  localparam int moduloSteps = tsfWidth - tuShift;
  localparam int stepCntWidth = $clog2(moduloSteps);
  // Count value during the last divider step
  localparam logic [stepCntWidth-1:0] lastStep = stepCntWidth'(moduloSteps - 1);

  //////////////////////////////
  // Controller states
  //////////////////////////////

  typedef enum logic [2:0] {
    idle             = 3'd0,
    checkUpdate      = 3'd1,
    updateTsf        = 3'd2,
    trigDivider      = 3'd3,
    waitModValid     = 3'd4,
    waitAnotherClock = 3'd5,
    updateBcnIntvCnt = 3'd6
  } tsfSyncState_e;

  //////////////////////////////
  // Grouped inputs
  //////////////////////////////

  // Timing fields of a received Beacon or Probe Response
  typedef struct packed {
    logic [tsfWidth-1:0]    timeStamp;
    logic [frmDurWidth-1:0] frmDurWithoutMH;
  } rxBeacon_t;

  // BSS configuration registers
  typedef struct packed {
    logic                      bssType;
    logic                      ap;
    logic [beaconIntWidth-1:0] beaconInt;
  } bssCfg_t;

  // Software TSF load request and value
  typedef struct packed {
    logic                    tsfUpdatedBySW;
    logic [tsfWidth/2-1:0]   tsfTimerHigh;
    logic [tsfWidth/2-1:0]   tsfTimerLow;
  } swLoad_t;

endpackage
